/* Bender.yml */
package:
  name: mtx_input_stage

sources:
  - include_dirs:
      - src
    files:
      - src/ahb_pkg.sv
      - src/mtx_pkg.sv
      - src/mtx_wrap_bound.sv
      - src/mtx_burst_term.sv
      - src/mtx_hold_reg.sv
      - src/mtx_pend_ctrl.sv
      - src/mtx_input_stage.sv
  - target: test
    include_dirs:
      - src
      - tests
    files:
      - tests/tb_mtx_input_stage.sv

/* mtx_input_stage.f */
+incdir+src
+incdir+tests
src/ahb_pkg.sv
src/mtx_pkg.sv
src/mtx_wrap_bound.sv
src/mtx_burst_term.sv
src/mtx_hold_reg.sv
src/mtx_pend_ctrl.sv
src/mtx_input_stage.sv
tests/tb_mtx_input_stage.sv

/* src/ahb_pkg.sv */
//------------------------------------------------------------
// AHB protocol encodings
// Transfer type, burst type, size and response
//------------------------------------------------------------
`include "mtx_settings.svh"

package ahb_pkg;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Master inserting a wait in a burst
    NONSEQ = 2'b10,  // First beat or single
    SEQ    = 2'b11   // Remaining burst beats
  } htrans_t;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,  // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // Bytes per beat as log2
  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'b000,
    SIZE_HALF  = 3'b001,
    SIZE_WORD  = 3'b010,
    SIZE_DWORD = 3'b011,
    SIZE_128   = 3'b100,
    SIZE_256   = 3'b101,
    SIZE_512   = 3'b110,
    SIZE_1024  = 3'b111
  } hsize_t;

  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10,
    SPLIT = 2'b11
  } hresp_t;

endpackage

/* src/mtx_burst_term.sv */
//------------------------------------------------------------
// Early burst termination
// Rewrites HTRANS and HBURST after an interrupted burst
//------------------------------------------------------------
module mtx_burst_term
  import ahb_pkg::*, mtx_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  haddr_t  HADDRS,
  input  hsize_t  HSIZES,
  input  hburst_t HBURSTS,
  input  htrans_t HTRANSS,
  input  logic    HREADYS,
  input  logic    load,
  input  logic    active_ip,
  input  htrans_t trans_sel,
  input  hburst_t burst_sel,
  input  htrans_t trans_src,
  output htrans_t trans_ip,
  output hburst_t burst_ip
);

  logic burst_override;  // Rest of burst finishes as INCR
  logic bound;

  mtx_wrap_bound u_wrap_bound (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HADDRS  (HADDRS),
    .HSIZES  (HSIZES),
    .HBURSTS (HBURSTS),
    .HTRANSS (HTRANSS),
    .HREADYS (HREADYS),
    .bound   (bound)
  );

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (HREADYS)
    begin
      if (HTRANSS == NONSEQ || HTRANSS == IDLE)
        burst_override <= 1'b0;                // New burst or none
      else if (HTRANSS == SEQ && load && !active_ip)
        burst_override <= 1'b1;                // Burst got cut off
    end
  end

  // Crossing a wrap in INCR mode needs a fresh NONSEQ, BUSY becomes IDLE
  assign trans_ip = (burst_override && bound) ? htrans_t'({trans_sel[1], 1'b0})
                                              : trans_sel;

  assign burst_ip = (burst_override && trans_src != NONSEQ) ? INCR : burst_sel;

endmodule

/* src/mtx_hold_reg.sv */
//------------------------------------------------------------
// Holding registers for one address phase
// Direct or held path select toward the output stage
//------------------------------------------------------------
module mtx_hold_reg
  import ahb_pkg::*, mtx_pkg::*;
(
  input  logic     HCLK,
  input  logic     HRESETn,
  input  logic     load,         // Capture strobe
  input  logic     pending,      // Held transfer waiting
  input  logic     HSELS,
  input  htrans_t  HTRANSS,
  input  haddr_t   HADDRS,
  input  logic     HWRITES,
  input  hsize_t   HSIZES,
  input  hburst_t  HBURSTS,
  input  hprot_t   HPROTS,
  input  hmaster_t HMASTERS,
  input  logic     HMASTLOCKS,
  output logic     sel_ip,
  output haddr_t   addr_ip,
  output logic     write_ip,
  output hsize_t   size_ip,
  output hprot_t   prot_ip,
  output hmaster_t master_ip,
  output logic     mastlock_ip,
  output htrans_t  trans_sel,    // Before burst termination rewrite
  output hburst_t  burst_sel,    // Before burst termination rewrite
  output htrans_t  trans_src     // Original HTRANS of the selected path
);

  htrans_t  reg_trans;
  haddr_t   reg_addr;
  logic     reg_write;
  hsize_t   reg_size;
  hburst_t  reg_burst;
  hprot_t   reg_prot;
  hmaster_t reg_master;
  logic     reg_mastlock;

  //----------------------------------------------------------
  // Capture on every accepted address phase
  //----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      reg_trans <= IDLE;
    else if (load)
      reg_trans <= HTRANSS;  // Only the type feeds back into control
  end

  always_ff @(posedge HCLK)
  begin
    if (load)
    begin
      reg_addr     <= HADDRS;
      reg_write    <= HWRITES;
      reg_size     <= HSIZES;
      reg_burst    <= HBURSTS;
      reg_prot     <= HPROTS;
      reg_master   <= HMASTERS;
      reg_mastlock <= HMASTLOCKS;
    end
  end

  // Held copy wins while the output stage has not taken it
  assign sel_ip      = pending ? 1'b1         : HSELS;
  assign trans_sel   = pending ? NONSEQ       : HTRANSS;  // Replay restarts the burst
  assign addr_ip     = pending ? reg_addr     : HADDRS;
  assign write_ip    = pending ? reg_write    : HWRITES;
  assign size_ip     = pending ? reg_size     : HSIZES;
  assign burst_sel   = pending ? reg_burst    : HBURSTS;
  assign prot_ip     = pending ? reg_prot     : HPROTS;
  assign master_ip   = pending ? reg_master   : HMASTERS;
  assign mastlock_ip = pending ? reg_mastlock : HMASTLOCKS;

  // Burst type choice looks at the real type, not the forced NONSEQ
  assign trans_src   = pending ? reg_trans    : HTRANSS;

endmodule

/* src/mtx_input_stage.sv */
//------------------------------------------------------------
// AHB matrix input stage top level
// Pending control, holding registers, burst termination
//------------------------------------------------------------
module mtx_input_stage
  import ahb_pkg::*, mtx_pkg::*;
(
  input  logic     HCLK,
  input  logic     HRESETn,
  // Master side address phase
  input  logic     HSELS,
  input  haddr_t   HADDRS,
  input  htrans_t  HTRANSS,
  input  logic     HWRITES,
  input  hsize_t   HSIZES,
  input  hburst_t  HBURSTS,
  input  hprot_t   HPROTS,
  input  hmaster_t HMASTERS,
  input  logic     HMASTLOCKS,
  input  logic     HREADYS,
  // Output stage feedback
  input  logic     active_ip,
  input  logic     readyout_ip,
  input  hresp_t   resp_ip,
  // Master side response
  output logic     HREADYOUTS,
  output hresp_t   HRESPS,
  // Toward the output stage
  output logic     sel_ip,
  output haddr_t   addr_ip,
  output htrans_t  trans_ip,
  output logic     write_ip,
  output hsize_t   size_ip,
  output hburst_t  burst_ip,
  output hprot_t   prot_ip,
  output hmaster_t master_ip,
  output logic     mastlock_ip,
  output logic     held_tran_ip
);

  logic    load;
  logic    pending;
  htrans_t trans_sel;
  hburst_t burst_sel;
  htrans_t trans_src;

  mtx_pend_ctrl u_pend_ctrl (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .HSELS        (HSELS),
    .HTRANSS      (HTRANSS),
    .HREADYS      (HREADYS),
    .active_ip    (active_ip),
    .readyout_ip  (readyout_ip),
    .resp_ip      (resp_ip),
    .load         (load),
    .pending      (pending),
    .held_tran_ip (held_tran_ip),
    .HREADYOUTS   (HREADYOUTS),
    .HRESPS       (HRESPS)
  );

  mtx_hold_reg u_hold_reg (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .load        (load),
    .pending     (pending),
    .HSELS       (HSELS),
    .HTRANSS     (HTRANSS),
    .HADDRS      (HADDRS),
    .HWRITES     (HWRITES),
    .HSIZES      (HSIZES),
    .HBURSTS     (HBURSTS),
    .HPROTS      (HPROTS),
    .HMASTERS    (HMASTERS),
    .HMASTLOCKS  (HMASTLOCKS),
    .sel_ip      (sel_ip),
    .addr_ip     (addr_ip),
    .write_ip    (write_ip),
    .size_ip     (size_ip),
    .prot_ip     (prot_ip),
    .master_ip   (master_ip),
    .mastlock_ip (mastlock_ip),
    .trans_sel   (trans_sel),
    .burst_sel   (burst_sel),
    .trans_src   (trans_src)
  );

  // Boundary check runs on the live address phase
  mtx_burst_term u_burst_term (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HADDRS    (HADDRS),
    .HSIZES    (HSIZES),
    .HBURSTS   (HBURSTS),
    .HTRANSS   (HTRANSS),
    .HREADYS   (HREADYS),
    .load      (load),
    .active_ip (active_ip),
    .trans_sel (trans_sel),
    .burst_sel (burst_sel),
    .trans_src (trans_src),
    .trans_ip  (trans_ip),
    .burst_ip  (burst_ip)
  );

endmodule

/* src/mtx_pend_ctrl.sv */
//------------------------------------------------------------
// Load strobe, data phase and pending tracking
// Request flag and master side response mux
//------------------------------------------------------------
module mtx_pend_ctrl
  import ahb_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  logic    HSELS,
  input  htrans_t HTRANSS,
  input  logic    HREADYS,
  input  logic    active_ip,     // Output stage serving this port
  input  logic    readyout_ip,
  input  hresp_t  resp_ip,
  output logic    load,          // Address phase accepted
  output logic    pending,       // Transfer sits in the holding regs
  output logic    held_tran_ip,  // Request to arbitration
  output logic    HREADYOUTS,
  output hresp_t  HRESPS
);

  logic addr_valid;
  logic data_valid;

  // NONSEQ or SEQ to this port
  assign addr_valid = HSELS & HTRANSS[1];
  assign load       = addr_valid & HREADYS;

  // Data phase follows the accepted address phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  //----------------------------------------------------------
  // Pending flag
  //----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pending <= 1'b0;
    else if (load && !active_ip)
      pending <= 1'b1;          // Output stage busy elsewhere
    else if (active_ip && readyout_ip)
      pending <= 1'b0;          // Held beat went out
  end

  assign held_tran_ip = load | pending;

  // Response back to the master
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;        // Idle data phase
      HRESPS     = OKAY;
    end
    else if (pending)
    begin
      HREADYOUTS = 1'b0;        // Stall until replay finishes
      HRESPS     = OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

endmodule

/* src/mtx_pkg.sv */
//------------------------------------------------------------
// Matrix internal types
//------------------------------------------------------------
`include "mtx_settings.svh"

package mtx_pkg;

  // Address and control payload
  typedef logic [`MTX_ADDR_W-1:0]   haddr_t;
  typedef logic [`MTX_PROT_W-1:0]   hprot_t;
  typedef logic [`MTX_MASTER_W-1:0] hmaster_t;

  // Beat index within a wrapping burst
  typedef logic [`MTX_WRAP_W-1:0]   wrap_off_t;

endpackage

/* src/mtx_settings.svh */
//------------------------------------------------------------
// Bus widths for the matrix input stage
// Wrap offset width for the boundary check
//------------------------------------------------------------
`ifndef MTX_SETTINGS_SVH
`define MTX_SETTINGS_SVH

`define MTX_ADDR_W    32  // HADDR width
`define MTX_PROT_W    4   // HPROT width
`define MTX_MASTER_W  4   // HMASTER width

// Beat index bits checked for a wrap, 16 beats max
`define MTX_WRAP_W    4

`endif

/* src/mtx_wrap_bound.sv */
//------------------------------------------------------------
// Wrap boundary detect for the current beat
//------------------------------------------------------------
module mtx_wrap_bound
  import ahb_pkg::*, mtx_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  haddr_t  HADDRS,
  input  hsize_t  HSIZES,
  input  hburst_t HBURSTS,
  input  htrans_t HTRANSS,
  input  logic    HREADYS,
  output logic    bound      // Previous beat closed a wrap block
);

  wrap_off_t offset_addr;
  wrap_off_t check_addr;

  // Beat index scaled by transfer size
  always_comb
  begin
    case (HSIZES)
      SIZE_BYTE:  offset_addr = HADDRS[3:0];
      SIZE_HALF:  offset_addr = HADDRS[4:1];
      SIZE_WORD:  offset_addr = HADDRS[5:2];
      SIZE_DWORD: offset_addr = HADDRS[6:3];
      default:    offset_addr = HADDRS[3:0];  // Wide sizes not handled
    endcase
  end

  // Ones above the wrap length, zeros for non-wrapping bursts
  always_comb
  begin
    case (HBURSTS)
      WRAP4:   check_addr = {2'b11, offset_addr[1:0]};
      WRAP8:   check_addr = {1'b1, offset_addr[2:0]};
      WRAP16:  check_addr = offset_addr;
      default: check_addr = '0;
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (HTRANSS[1] && HREADYS)
      bound <= &check_addr;     // Last beat before wrap
  end

endmodule

/* tests/mtx_ref_model.svh */
//------------------------------------------------------------
// Reference state of the input stage, expected outputs, LCG
//------------------------------------------------------------
`ifndef MTX_REF_MODEL_SVH
`define MTX_REF_MODEL_SVH

typedef struct packed {
  logic     held_tran;
  logic     hreadyout;
  hresp_t   hresp;
  logic     sel;
  haddr_t   addr;
  htrans_t  trans;
  logic     write;
  hsize_t   size;
  hburst_t  burst;
  hprot_t   prot;
  hmaster_t master;
  logic     mastlock;
} expect_t;

// Mirrored registers of the DUT
logic     ref_pending    = 1'b0;
logic     ref_data_valid = 1'b0;
logic     ref_override   = 1'b0;  // Cut burst finishes as INCR
logic     ref_bound      = 1'b0;  // Last beat closed a wrap block
htrans_t  ref_trans      = IDLE;
haddr_t   ref_addr       = '0;
logic     ref_write      = 1'b0;
hsize_t   ref_size       = SIZE_BYTE;
hburst_t  ref_burst      = SINGLE;
hprot_t   ref_prot       = '0;
hmaster_t ref_master     = '0;
logic     ref_mastlock   = 1'b0;

logic [31:0] lcg_state = 32'h0ca45981;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Beat index of this address is the last one in its wrap block
function automatic logic last_wrap_beat(haddr_t addr, hsize_t size, hburst_t burst);
  haddr_t     beat;
  logic [3:0] len_mask;
  beat = (size < 4) ? (addr >> size) : addr;  // Wide sizes count in bytes
  case (burst)
    WRAP4:   len_mask = 4'h3;
    WRAP8:   len_mask = 4'h7;
    WRAP16:  len_mask = 4'hf;
    default: return 1'b0;
  endcase
  return (beat[3:0] | ~len_mask) == 4'hf;
endfunction

function automatic logic live_valid();
  return HSELS && (HTRANSS == NONSEQ || HTRANSS == SEQ);
endfunction

// Register update at the rising edge
task automatic update_ref_state();
  logic load;
  load = live_valid() && HREADYS;
  if (!HRESETn)
  begin
    ref_pending    = 1'b0;
    ref_data_valid = 1'b0;
    ref_override   = 1'b0;
    ref_bound      = 1'b0;
    ref_trans      = IDLE;
  end
  else
  begin
    if (HREADYS)
      ref_data_valid = live_valid();
    if (load && !active_ip)
      ref_pending = 1'b1;   // Set beats clear
    else if (active_ip && readyout_ip)
      ref_pending = 1'b0;
    if (HREADYS && (HTRANSS == NONSEQ || HTRANSS == SEQ))
      ref_bound = last_wrap_beat(HADDRS, HSIZES, HBURSTS);
    if (HREADYS && (HTRANSS == NONSEQ || HTRANSS == IDLE))
      ref_override = 1'b0;
    else if (HREADYS && HTRANSS == SEQ && load && !active_ip)
      ref_override = 1'b1;
    if (load)
    begin
      ref_trans    = HTRANSS;
      ref_addr     = HADDRS;
      ref_write    = HWRITES;
      ref_size     = HSIZES;
      ref_burst    = HBURSTS;
      ref_prot     = HPROTS;
      ref_master   = HMASTERS;
      ref_mastlock = HMASTLOCKS;
    end
  end
endtask

// Expected outputs from the mirrored state and the live inputs
function automatic expect_t expected_outputs();
  expect_t e;
  logic    held;
  held        = ref_pending;
  e.held_tran = (live_valid() && HREADYS) || held;
  if (!ref_data_valid)
  begin
    e.hreadyout = 1'b1;
    e.hresp     = OKAY;
  end
  else if (held)
  begin
    e.hreadyout = 1'b0;   // Master waits for the replay
    e.hresp     = OKAY;
  end
  else
  begin
    e.hreadyout = readyout_ip;
    e.hresp     = resp_ip;
  end
  e.sel      = held ? 1'b1 : HSELS;
  e.addr     = held ? ref_addr : HADDRS;
  e.write    = held ? ref_write : HWRITES;
  e.size     = held ? ref_size : HSIZES;
  e.prot     = held ? ref_prot : HPROTS;
  e.master   = held ? ref_master : HMASTERS;
  e.mastlock = held ? ref_mastlock : HMASTLOCKS;
  e.trans    = held ? NONSEQ : HTRANSS;  // Replay restarts
  if (ref_override && ref_bound)
  begin
    if (e.trans == SEQ)
      e.trans = NONSEQ;   // New INCR burst after the wrap point
    else if (e.trans == BUSY)
      e.trans = IDLE;
  end
  e.burst = held ? ref_burst : HBURSTS;
  if (ref_override && ((held ? ref_trans : HTRANSS) != NONSEQ))
    e.burst = INCR;
  return e;
endfunction

`endif

/* tests/tb_mtx_input_stage.sv */
//------------------------------------------------------------
// Testbench for the matrix input stage
// Directed and LCG random stimulus against a reference model
//------------------------------------------------------------
module tb_mtx_input_stage
  import ahb_pkg::*, mtx_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DIRECTED_CYCLES = 120;   // Upper bound on reset and directed cycles
  localparam int RANDOM_CYCLES   = 2000;
  localparam int TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 80;

  logic     HCLK;
  logic     HRESETn;
  logic     HSELS;
  haddr_t   HADDRS;
  htrans_t  HTRANSS;
  logic     HWRITES;
  hsize_t   HSIZES;
  hburst_t  HBURSTS;
  hprot_t   HPROTS;
  hmaster_t HMASTERS;
  logic     HMASTLOCKS;
  logic     HREADYS;
  logic     active_ip;
  logic     readyout_ip;
  hresp_t   resp_ip;
  logic     HREADYOUTS;
  hresp_t   HRESPS;
  logic     sel_ip;
  haddr_t   addr_ip;
  htrans_t  trans_ip;
  logic     write_ip;
  hsize_t   size_ip;
  hburst_t  burst_ip;
  hprot_t   prot_ip;
  hmaster_t master_ip;
  logic     mastlock_ip;
  logic     held_tran_ip;
  int       cycle_count = 0;

`include "mtx_ref_model.svh"

  mtx_input_stage mtx_input_stage_i (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .HSELS        (HSELS),
    .HADDRS       (HADDRS),
    .HTRANSS      (HTRANSS),
    .HWRITES      (HWRITES),
    .HSIZES       (HSIZES),
    .HBURSTS      (HBURSTS),
    .HPROTS       (HPROTS),
    .HMASTERS     (HMASTERS),
    .HMASTLOCKS   (HMASTLOCKS),
    .HREADYS      (HREADYS),
    .active_ip    (active_ip),
    .readyout_ip  (readyout_ip),
    .resp_ip      (resp_ip),
    .HREADYOUTS   (HREADYOUTS),
    .HRESPS       (HRESPS),
    .sel_ip       (sel_ip),
    .addr_ip      (addr_ip),
    .trans_ip     (trans_ip),
    .write_ip     (write_ip),
    .size_ip      (size_ip),
    .burst_ip     (burst_ip),
    .prot_ip      (prot_ip),
    .master_ip    (master_ip),
    .mastlock_ip  (mastlock_ip),
    .held_tran_ip (held_tran_ip)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;   // 20 ns period
  end

  always @(posedge HCLK)
    update_ref_state();

  //----------------------------------------------------------
  // Checking
  //----------------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // Outputs settle well before the falling edge
  initial
  begin
    expect_t exp_out;
    @(posedge HCLK);
    forever
    begin
      @(negedge HCLK);
      exp_out = expected_outputs();
      compare_value("HREADYOUTS", exp_out.hreadyout, HREADYOUTS);
      compare_value("HRESPS", exp_out.hresp, HRESPS);
      compare_value("held_tran_ip", exp_out.held_tran, held_tran_ip);
      compare_value("sel_ip", exp_out.sel, sel_ip);
      compare_value("addr_ip", exp_out.addr, addr_ip);
      compare_value("trans_ip", exp_out.trans, trans_ip);
      compare_value("write_ip", exp_out.write, write_ip);
      compare_value("size_ip", exp_out.size, size_ip);
      compare_value("burst_ip", exp_out.burst, burst_ip);
      compare_value("prot_ip", exp_out.prot, prot_ip);
      compare_value("master_ip", exp_out.master, master_ip);
      compare_value("mastlock_ip", exp_out.mastlock, mastlock_ip);
    end
  end

  always @(posedge HCLK)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  //----------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------
  // One address phase with LCG side payload
  task automatic drive_cycle(input logic sel, input htrans_t trans, input haddr_t addr,
                             input hsize_t size, input hburst_t burst, input logic ready,
                             input logic active, input logic rdy_out, input hresp_t resp);
    logic [31:0] r;
    r = lcg_next();
    @(posedge HCLK);
    #1;
    HSELS       = sel;
    HTRANSS     = trans;
    HADDRS      = addr;
    HSIZES      = size;
    HBURSTS     = burst;
    HREADYS     = ready;
    active_ip   = active;
    readyout_ip = rdy_out;
    resp_ip     = resp;
    HWRITES     = r[31];
    HPROTS      = r[30:27];
    HMASTERS    = r[26:23];
    HMASTLOCKS  = r[22];
  endtask

  // Biased toward SEQ beats and active_ip dropouts
  task automatic random_cycle();
    logic [31:0] r;
    logic [31:0] a_hi;
    logic [31:0] a_lo;
    r    = lcg_next();
    a_hi = lcg_next();
    a_lo = lcg_next();
    @(posedge HCLK);
    #1;
    HSELS = r[31:30] != 2'b00;
    case (r[29:27])
      3'd0:       HTRANSS = IDLE;
      3'd1:       HTRANSS = BUSY;
      3'd2, 3'd3: HTRANSS = NONSEQ;
      default:    HTRANSS = SEQ;
    endcase
    HADDRS      = {a_hi[31:16], a_lo[31:16]};
    HSIZES      = hsize_t'(r[26] ? r[25:23] : {1'b0, r[24:23]});  // Mostly 0 to 3
    HBURSTS     = hburst_t'(r[22:20]);
    HREADYS     = r[19:17] != 3'b000;
    active_ip   = r[16:14] > 3'd2;
    readyout_ip = r[13:12] != 2'b00;
    resp_ip     = r[11] ? hresp_t'(r[10:9]) : OKAY;
    HWRITES     = a_lo[15];
    HPROTS      = a_lo[14:11];
    HMASTERS    = a_hi[14:11];
    HMASTLOCKS  = a_hi[15];
  endtask

  function automatic haddr_t beat_addr(int k, int beats, int size);
    return 32'h0000_8000 + ((k % beats) << size);
  endfunction

  initial
  begin
    int      beats;
    hsize_t  sz;
    hburst_t wrap_kind;
    // Live address phase and a stalled slave while in reset
    HRESETn     = 1'b0;
    HSELS       = 1'b1;
    HADDRS      = '0;
    HTRANSS     = NONSEQ;
    HWRITES     = 1'b0;
    HSIZES      = SIZE_BYTE;
    HBURSTS     = SINGLE;
    HPROTS      = '0;
    HMASTERS    = '0;
    HMASTLOCKS  = 1'b0;
    HREADYS     = 1'b1;
    active_ip   = 1'b1;
    readyout_ip = 1'b0;
    resp_ip     = ERROR;
    repeat (2) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;

    // Pass-through and response forwarding
    drive_cycle(1'b1, NONSEQ, 32'h0000_1000, SIZE_WORD, SINGLE, 1'b1, 1'b1, 1'b1, OKAY);
    drive_cycle(1'b1, NONSEQ, 32'h0000_2004, SIZE_HALF, INCR, 1'b1, 1'b1, 1'b0, OKAY);
    drive_cycle(1'b1, IDLE, 32'h0000_2006, SIZE_HALF, INCR, 1'b1, 1'b1, 1'b1, ERROR);
    drive_cycle(1'b0, NONSEQ, 32'h0000_3000, SIZE_WORD, SINGLE, 1'b1, 1'b1, 1'b1, OKAY);

    // Capture while another port owns the output, then replay
    drive_cycle(1'b1, NONSEQ, 32'h0000_4000, SIZE_WORD, INCR4, 1'b1, 1'b0, 1'b1, OKAY);
    repeat (3)
      drive_cycle(1'b1, SEQ, 32'h0000_4004, SIZE_WORD, INCR4, 1'b0, 1'b0, 1'b1, OKAY);
    drive_cycle(1'b1, SEQ, 32'h0000_4004, SIZE_WORD, INCR4, 1'b0, 1'b1, 1'b0, OKAY);
    drive_cycle(1'b1, SEQ, 32'h0000_4004, SIZE_WORD, INCR4, 1'b0, 1'b1, 1'b1, OKAY);
    drive_cycle(1'b1, SEQ, 32'h0000_4004, SIZE_WORD, INCR4, 1'b1, 1'b1, 1'b1, OKAY);
    drive_cycle(1'b0, IDLE, 32'h0000_0000, SIZE_WORD, SINGLE, 1'b1, 1'b1, 1'b1, OKAY);

    // Wrap bursts cut on the last beat before the wrap point
    for (int s = 0; s < 4; s++)
    begin
      for (int w = 0; w < 3; w++)
      begin
        wrap_kind = (w == 0) ? WRAP4 : (w == 1) ? WRAP8 : WRAP16;
        beats     = 4 << w;
        sz        = hsize_t'(s);
        drive_cycle(1'b1, NONSEQ, beat_addr(beats - 2, beats, s), sz, wrap_kind,
                    1'b1, 1'b1, 1'b1, OKAY);
        drive_cycle(1'b1, SEQ, beat_addr(beats - 1, beats, s), sz, wrap_kind,
                    1'b1, 1'b0, 1'b1, OKAY);   // Dropout here
        drive_cycle(1'b1, SEQ, beat_addr(0, beats, s), sz, wrap_kind,
                    1'b0, 1'b0, 1'b1, OKAY);
        drive_cycle(1'b1, SEQ, beat_addr(0, beats, s), sz, wrap_kind,
                    1'b0, 1'b1, 1'b1, OKAY);   // Replay taken
        drive_cycle(1'b1, SEQ, beat_addr(0, beats, s), sz, wrap_kind,
                    1'b1, 1'b1, 1'b1, OKAY);
        drive_cycle(1'b1, SEQ, beat_addr(1, beats, s), sz, wrap_kind,
                    1'b1, 1'b1, 1'b1, OKAY);
        drive_cycle(1'b0, IDLE, 32'h0000_0000, sz, SINGLE, 1'b1, 1'b1, 1'b1, OKAY);
      end
    end

    repeat (RANDOM_CYCLES)
      random_cycle();

    drive_cycle(1'b0, IDLE, 32'h0000_0000, SIZE_BYTE, SINGLE, 1'b1, 1'b1, 1'b1, OKAY);
    drive_cycle(1'b0, IDLE, 32'h0000_0000, SIZE_BYTE, SINGLE, 1'b1, 1'b1, 1'b1, OKAY);
    @(negedge HCLK);
    #1;
    $display("Everything OK");
    $finish;
  end

endmodule
